// File: source/tap_pkg.sv
// Shared TAP widths, instruction codes and controller states; codes outside this list act as bypass
package tap_pkg;

   // **********************************************************
   // Register lengths
   // **********************************************************
   localparam int unsigned ir_width     = 4;
   localparam int unsigned ctrl_width   = 8;
   localparam int unsigned status_width = 16;

   typedef logic [ir_width-1:0]     ir_t;
   typedef logic [ctrl_width-1:0]   ctrl_t;
   typedef logic [status_width-1:0] status_t;

   // **********************************************************
   // Instruction codes
   // **********************************************************
   // Bypass is all ones and is also the instruction after reset
   localparam ir_t instr_bypass = '1;
   localparam ir_t instr_ctrl   = 4'h2;
   localparam ir_t instr_status = 4'h3;

   // Fixed pattern seen on TDO during every IR scan
   localparam ir_t ir_capture_value = 4'b0001;

   // Control register value after reset or test-logic-reset
   localparam ctrl_t ctrl_reset_value = 8'h5A;

   // **********************************************************
   // TAP controller states, standard 16-state diagram
   // **********************************************************
   typedef enum logic [3:0] {
      st_test_logic_reset, st_run_test_idle,
      st_select_dr_scan,   st_capture_dr,  st_shift_dr,  st_exit1_dr,
      st_pause_dr,         st_exit2_dr,    st_update_dr,
      st_select_ir_scan,   st_capture_ir,  st_shift_ir,  st_exit1_ir,
      st_pause_ir,         st_exit2_ir,    st_update_ir
   } tap_state_t;

endpackage

// File: source/tap_fsm.sv
// TAP controller; strobes are decoded from the state register and last one full TCK cycle each
`timescale 1ns/100ps

module tap_fsm
(
   input  logic atappris_tck,
   input  logic reset_b,
   input  logic atappris_tms,
   output logic tlrs,
   output logic capture_dr,
   output logic shift_dr,
   output logic update_dr,
   output logic capture_ir,
   output logic shift_ir,
   output logic update_ir,
   output logic shift_any
);

   import tap_pkg::*;

   tap_state_t state;
   tap_state_t state_nxt;

   // **********************************************************
   // Next state, follows TMS
   // **********************************************************
   always_comb
   begin
      case (state)
         st_test_logic_reset : state_nxt = atappris_tms ? st_test_logic_reset : st_run_test_idle;
         st_run_test_idle    : state_nxt = atappris_tms ? st_select_dr_scan : st_run_test_idle;
         // DR column
         st_select_dr_scan   : state_nxt = atappris_tms ? st_select_ir_scan : st_capture_dr;
         st_capture_dr       : state_nxt = atappris_tms ? st_exit1_dr : st_shift_dr;
         st_shift_dr         : state_nxt = atappris_tms ? st_exit1_dr : st_shift_dr;
         st_exit1_dr         : state_nxt = atappris_tms ? st_update_dr : st_pause_dr;
         st_pause_dr         : state_nxt = atappris_tms ? st_exit2_dr : st_pause_dr;
         st_exit2_dr         : state_nxt = atappris_tms ? st_update_dr : st_shift_dr;
         st_update_dr        : state_nxt = atappris_tms ? st_select_dr_scan : st_run_test_idle;
         // IR column
         st_select_ir_scan   : state_nxt = atappris_tms ? st_test_logic_reset : st_capture_ir;
         st_capture_ir       : state_nxt = atappris_tms ? st_exit1_ir : st_shift_ir;
         st_shift_ir         : state_nxt = atappris_tms ? st_exit1_ir : st_shift_ir;
         st_exit1_ir         : state_nxt = atappris_tms ? st_update_ir : st_pause_ir;
         st_pause_ir         : state_nxt = atappris_tms ? st_exit2_ir : st_pause_ir;
         st_exit2_ir         : state_nxt = atappris_tms ? st_update_ir : st_shift_ir;
         st_update_ir        : state_nxt = atappris_tms ? st_select_dr_scan : st_run_test_idle;
         default             : state_nxt = st_test_logic_reset;
      endcase
   end

   // **********************************************************
   // State register
   // **********************************************************
   // Any state reaches test-logic-reset after at most five TMS highs
   always_ff @(posedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         state <= st_test_logic_reset;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // **********************************************************
   // Strobe decode
   // **********************************************************
   // Pure state decode so each strobe spans exactly its state
   assign tlrs       = (state == st_test_logic_reset);
   assign capture_dr = (state == st_capture_dr);
   assign shift_dr   = (state == st_shift_dr);
   assign update_dr  = (state == st_update_dr);
   assign capture_ir = (state == st_capture_ir);
   assign shift_ir   = (state == st_shift_ir);
   assign update_ir  = (state == st_update_ir);

   // Either shift state, used by the TDO stage
   assign shift_any  = shift_dr | shift_ir;

endmodule

// File: source/tap_instr_reg.sv
// Instruction path with decode, bypass bit and TDO stage; unknown codes fall back to bypass
`timescale 1ns/100ps

module tap_instr_reg
(
   input  logic atappris_tck,
   input  logic reset_b,
   input  logic atappris_tdi,
   input  logic tlrs,
   input  logic capture_ir,
   input  logic shift_ir,
   input  logic update_ir,
   input  logic capture_dr,
   input  logic shift_dr,
   input  logic shift_any,
   input  logic ctrl_drout,
   input  logic status_drout,
   output logic ctrl_select,
   output logic status_select,
   output logic atappris_tdo,
   output logic atappris_tdo_en
);

   import tap_pkg::*;

   ir_t  ir_shift;
   ir_t  ir_current;
   logic bypass_select;
   logic bypass_bit;
   logic dr_bit;

   // **********************************************************
   // Instruction shift register
   // **********************************************************
   // Capture loads the fixed 0001 pattern, shift is LSB first
   always_ff @(posedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         ir_shift <= ir_capture_value;
      end
      else if (capture_ir)
      begin
         ir_shift <= ir_capture_value;
      end
      else if (shift_ir)
      begin
         ir_shift <= {atappris_tdi, ir_shift[ir_width-1:1]};
      end
   end

   // Current instruction, loaded mid-cycle in update-IR
   always_ff @(negedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         ir_current <= instr_bypass;
      end
      else if (tlrs)
      begin
         ir_current <= instr_bypass;
      end
      else if (update_ir)
      begin
         ir_current <= ir_shift;
      end
   end

   // **********************************************************
   // Decode
   // **********************************************************
   assign ctrl_select   = (ir_current == instr_ctrl);
   assign status_select = (ir_current == instr_status);
   // Everything else, including unused codes
   assign bypass_select = ~ctrl_select & ~status_select;

   // Bypass flop, one bit of delay from TDI to TDO
   always_ff @(posedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         bypass_bit <= 1'b0;
      end
      else if (capture_dr & bypass_select)
      begin
         bypass_bit <= 1'b0;
      end
      else if (shift_dr & bypass_select)
      begin
         bypass_bit <= atappris_tdi;
      end
   end

   // **********************************************************
   // TDO stage
   // **********************************************************
   // Data side pick follows the current instruction
   assign dr_bit = ctrl_select   ? ctrl_drout   :
                   status_select ? status_drout : bypass_bit;

   // Falling edge register so TDO is stable at the host's rising edge
   always_ff @(negedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         atappris_tdo    <= 1'b0;
         atappris_tdo_en <= 1'b0;
      end
      else
      begin
         atappris_tdo    <= shift_ir ? ir_shift[0] : (shift_any & dr_bit);
         atappris_tdo_en <= shift_any;
      end
   end

endmodule

// File: source/tap_data_reg.sv
// Generic test data register; mask bit 1 captures data_in, 0 loops data_out back on capture
`timescale 1ns/100ps

module tap_data_reg
#(
   parameter int unsigned            width                 = 8,
   parameter logic [width-1:0]       reset_value           = '0,
   parameter logic [width-1:0]       capture_from_pin_mask = '0
)
(
   input  logic             atappris_tck,
   input  logic             reset_b,
   input  logic             tlrs,
   input  logic             atappris_tdi,
   input  logic             drselect,
   input  logic             capture_dr,
   input  logic             shift_dr,
   input  logic             update_dr,
   input  logic [width-1:0] data_in,
   output logic             drout,
   output logic [width-1:0] data_out
);

   logic [width-1:0] shift_reg;
   logic [width-1:0] capture_mix;
   logic [width-1:0] shift_nxt;

   // **********************************************************
   // Capture source, per bit pin or loopback
   // **********************************************************
   assign capture_mix = (data_in & capture_from_pin_mask) | (data_out & ~capture_from_pin_mask);

   // TDI enters at the top, a 1-bit register just takes TDI
   generate
      if (width > 1)
      begin : g_wide
         assign shift_nxt = {atappris_tdi, shift_reg[width-1:1]};
      end
      else
      begin : g_single
         assign shift_nxt = atappris_tdi;
      end
   endgenerate

   // **********************************************************
   // Shift register
   // **********************************************************
   always_ff @(posedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         shift_reg <= reset_value;
      end
      else if (tlrs)
      begin
         shift_reg <= reset_value;
      end
      else if (capture_dr & drselect)
      begin
         shift_reg <= capture_mix;
      end
      else if (shift_dr & drselect)
      begin
         shift_reg <= shift_nxt;
      end
   end

   // Bit 0 goes to the TDO multiplexer
   assign drout = shift_reg[0];

   // Parallel output, loaded on the falling edge inside update-DR
   always_ff @(negedge atappris_tck or negedge reset_b)
   begin
      if (!reset_b)
      begin
         data_out <= reset_value;
      end
      else if (tlrs)
      begin
         data_out <= reset_value;
      end
      else if (update_dr & drselect)
      begin
         data_out <= shift_reg;
      end
   end

endmodule

// File: source/tap_top.sv
// TAP top with control and status registers only; no IDCODE, boundary scan or TAP chaining
`timescale 1ns/100ps

module tap_top
#(
   parameter tap_pkg::ctrl_t ctrl_reset = tap_pkg::ctrl_reset_value
)
(
   input  logic             atappris_tck,
   input  logic             reset_b,
   input  logic             atappris_tms,
   input  logic             atappris_tdi,
   input  tap_pkg::status_t status_in,
   output logic             atappris_tdo,
   output logic             atappris_tdo_en,
   output tap_pkg::ctrl_t   ctrl_out
);

   import tap_pkg::*;

   // Controller strobes
   logic tlrs;
   logic capture_dr;
   logic shift_dr;
   logic update_dr;
   logic capture_ir;
   logic shift_ir;
   logic update_ir;
   logic shift_any;

   // Decode and serial return paths
   logic ctrl_select;
   logic status_select;
   logic ctrl_drout;
   logic status_drout;

   // **********************************************************
   // Controller
   // **********************************************************
   tap_fsm i_tap_fsm (
      .atappris_tck (atappris_tck),
      .reset_b      (reset_b),
      .atappris_tms (atappris_tms),
      .tlrs         (tlrs),
      .capture_dr   (capture_dr),
      .shift_dr     (shift_dr),
      .update_dr    (update_dr),
      .capture_ir   (capture_ir),
      .shift_ir     (shift_ir),
      .update_ir    (update_ir),
      .shift_any    (shift_any)
   );

   // **********************************************************
   // Instruction path and TDO stage
   // **********************************************************
   tap_instr_reg i_tap_instr_reg (
      .atappris_tck    (atappris_tck),
      .reset_b         (reset_b),
      .atappris_tdi    (atappris_tdi),
      .tlrs            (tlrs),
      .capture_ir      (capture_ir),
      .shift_ir        (shift_ir),
      .update_ir       (update_ir),
      .capture_dr      (capture_dr),
      .shift_dr        (shift_dr),
      .shift_any       (shift_any),
      .ctrl_drout      (ctrl_drout),
      .status_drout    (status_drout),
      .ctrl_select     (ctrl_select),
      .status_select   (status_select),
      .atappris_tdo    (atappris_tdo),
      .atappris_tdo_en (atappris_tdo_en)
   );

   // **********************************************************
   // Data registers
   // **********************************************************
   // Control, full loopback, data_in only closes the port
   tap_data_reg #(
      .width                 (ctrl_width),
      .reset_value           (ctrl_reset),
      .capture_from_pin_mask ({ctrl_width{1'b0}})
   ) i_ctrl_reg (
      .atappris_tck (atappris_tck),
      .reset_b      (reset_b),
      .tlrs         (tlrs),
      .atappris_tdi (atappris_tdi),
      .drselect     (ctrl_select),
      .capture_dr   (capture_dr),
      .shift_dr     (shift_dr),
      .update_dr    (update_dr),
      .data_in      (ctrl_out),
      .drout        (ctrl_drout),
      .data_out     (ctrl_out)
   );

   // Status, every bit from the pins
   tap_data_reg #(
      .width                 (status_width),
      .reset_value           ({status_width{1'b0}}),
      .capture_from_pin_mask ({status_width{1'b1}})
   ) i_status_reg (
      .atappris_tck (atappris_tck),
      .reset_b      (reset_b),
      .tlrs         (tlrs),
      .atappris_tdi (atappris_tdi),
      .drselect     (status_select),
      .capture_dr   (capture_dr),
      .shift_dr     (shift_dr),
      .update_dr    (update_dr),
      .data_in      (status_in),
      .drout        (status_drout),
      .data_out     ()
   );

endmodule

// File: sim/tap_clock_gen.sv
// TCK with a 40 ns period; reset_b is released a quarter period after two cycles, away from both edges
`timescale 1ns/100ps

module tap_clock_gen
#(
   parameter int period       = 40,
   parameter int reset_cycles = 2
)
(
   output logic atappris_tck,
   output logic reset_b
);

   initial
   begin
      atappris_tck = 1'b0;
      forever #(period / 2) atappris_tck = ~atappris_tck;
   end

   // Release lands between a falling and a rising edge
   initial
   begin
      reset_b = 1'b0;
      #(reset_cycles * period + period / 4);
      reset_b = 1'b1;
   end

endmodule

// File: sim/tap_checker.sv
// TAP protocol assertions sampled on rising TCK; all of them are off while reset_b is low
`timescale 1ns/100ps

module tap_checker
(
   input logic           atappris_tck,
   input logic           reset_b,
   input logic           atappris_tdo_en,
   input logic           tlrs,
   input logic           capture_dr,
   input logic           shift_dr,
   input logic           update_dr,
   input logic           capture_ir,
   input logic           shift_ir,
   input logic           update_ir,
   input logic           shift_any,
   input tap_pkg::ctrl_t ctrl_out
);

   // Failure tally, read by the testbench at the end of the run
   int fail_count = 0;

   // **********************************************************
   // Output enable and strobes
   // **********************************************************
   // TDO enable is set at the falling edge of a shift cycle only
   tdo_en_in_shift : assert property (@(posedge atappris_tck) disable iff (!reset_b)
      atappris_tdo_en |-> shift_any)
   else
   begin
      $error("TDO enable high outside a shift state");
      fail_count++;
   end

   // One controller state at a time, so at most one strobe
   strobes_exclusive : assert property (@(posedge atappris_tck) disable iff (!reset_b)
      $onehot0({tlrs, capture_dr, shift_dr, update_dr, capture_ir, shift_ir, update_ir}))
   else
   begin
      $error("More than one TAP strobe active");
      fail_count++;
   end

   // **********************************************************
   // Control register output
   // **********************************************************
   // A change lands at the falling edge of an update-DR or test-logic-reset cycle
   ctrl_after_update : assert property (@(posedge atappris_tck) disable iff (!reset_b)
      !$stable(ctrl_out) |-> (update_dr || tlrs))
   else
   begin
      $error("ctrl_out changed outside update-DR and test-logic-reset");
      fail_count++;
   end

endmodule

bind tap_top tap_checker i_tap_checker (
   .atappris_tck    (atappris_tck),
   .reset_b         (reset_b),
   .atappris_tdo_en (atappris_tdo_en),
   .tlrs            (tlrs),
   .capture_dr      (capture_dr),
   .shift_dr        (shift_dr),
   .update_dr       (update_dr),
   .capture_ir      (capture_ir),
   .shift_ir        (shift_ir),
   .update_ir       (update_ir),
   .shift_any       (shift_any),
   .ctrl_out        (ctrl_out)
);

// File: sim/tap_tb.sv
// Directed TAP tests; every scan moves 2 to 16 bits LSB first and starts and ends in run-test-idle
`timescale 1ns/100ps

module tap_tb;

   import tap_pkg::*;

   // Cycles any wait may take before it counts as a timeout
   localparam int wait_limit = 8;

   logic    atappris_tck;
   logic    reset_b;
   logic    atappris_tms;
   logic    atappris_tdi;
   status_t status_in;
   logic    atappris_tdo;
   logic    atappris_tdo_en;
   ctrl_t   ctrl_out;

   int          errors;
   int          timeouts;
   ctrl_t       exp_ctrl;
   logic [31:0] lfsr_state;

   tap_clock_gen i_tap_clock_gen (
      .atappris_tck (atappris_tck),
      .reset_b      (reset_b)
   );

   tap_top #(
      .ctrl_reset (ctrl_reset_value)
   ) i_tap_top (
      .atappris_tck    (atappris_tck),
      .reset_b         (reset_b),
      .atappris_tms    (atappris_tms),
      .atappris_tdi    (atappris_tdi),
      .status_in       (status_in),
      .atappris_tdo    (atappris_tdo),
      .atappris_tdo_en (atappris_tdo_en),
      .ctrl_out        (ctrl_out)
   );

   // **********************************************************
   // Random bits, 32-bit Fibonacci LFSR with taps 32 22 2 1
   // **********************************************************
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   function automatic logic [15:0] random_bits(input int n);
      logic [15:0] value;
      value = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         value      = {value[14:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // **********************************************************
   // Compare tasks
   // **********************************************************
   task automatic check_ctrl(input string name, input ctrl_t expected, input ctrl_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_status(input string name, input status_t expected, input status_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_ir(input string name, input ir_t expected, input ir_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
         errors++;
      end
   endtask

   // **********************************************************
   // Pin level
   // **********************************************************
   // TMS and TDI change 2 ns after the rising edge that starts a cycle
   task automatic drive_pins(input logic tms, input logic tdi);
      @(posedge atappris_tck);
      #2;
      atappris_tms = tms;
      atappris_tdi = tdi;
   endtask

   // IR or DR scan from idle back to idle, TDO sampled 1 ns after each falling edge
   task automatic scan(input logic ir, input int n, input logic [15:0] din,
                       output logic [15:0] dout);
      int   waited;
      logic seen;
      dout   = '0;
      waited = 0;
      seen   = 1'b0;
      drive_pins(1'b1, 1'b0);
      if (ir)
      begin
         drive_pins(1'b1, 1'b0);
      end
      drive_pins(1'b0, 1'b0);
      // Capture cycle first, then TDO enable rises in the first shift cycle
      while (!seen && waited < wait_limit)
      begin
         drive_pins(1'b0, din[0]);
         @(negedge atappris_tck);
         #1;
         seen = atappris_tdo_en;
         waited++;
      end
      if (!seen)
      begin
         $display("Timeout: no shift state reached within %0d cycles", wait_limit);
         timeouts++;
      end
      dout[0] = atappris_tdo;
      // TMS high on the last bit leaves for exit1
      for (int i = 1; i < n; i++)
      begin
         drive_pins(i == n - 1, din[i]);
         @(negedge atappris_tck);
         #1;
         dout[i] = atappris_tdo;
      end
      drive_pins(1'b1, 1'b0);
      drive_pins(1'b0, 1'b0);
      // Update acts at this falling edge
      @(negedge atappris_tck);
      #1;
   endtask

   task automatic load_instr(input string name, input ir_t code);
      logic [15:0] dout;
      scan(1'b1, ir_width, {12'h000, code}, dout);
      check_ir(name, ir_capture_value, dout[ir_width-1:0]);
   endtask

   // **********************************************************
   // Tests
   // **********************************************************
   task automatic test_reset();
      check_ctrl("reset ctrl_out", ctrl_reset_value, ctrl_out);
      check_bit("reset tdo_en", 1'b0, atappris_tdo_en);
      drive_pins(1'b0, 1'b0);
      // Instruction left by reset, before any IR scan
      test_bypass("bypass default");
      load_instr("reset ir capture", instr_bypass);
   endtask

   task automatic test_bypass(input string name);
      logic [15:0] bits;
      logic [15:0] dout;
      logic [15:0] expected;
      bits = random_bits(16);
      scan(1'b0, 16, bits, dout);
      // Captured 0 leads, each TDI bit follows one shift later
      expected = {bits[14:0], 1'b0};
      for (int i = 0; i < 16; i++)
      begin
         check_bit($sformatf("%s bit %0d", name, i), expected[i], dout[i]);
      end
      check_ctrl({name, " ctrl_out"}, exp_ctrl, ctrl_out);
   endtask

   task automatic test_ctrl();
      logic [15:0] value;
      logic [15:0] dout;
      load_instr("ctrl ir capture", instr_ctrl);
      value = random_bits(ctrl_width);
      scan(1'b0, ctrl_width, value, dout);
      check_ctrl("ctrl capture", exp_ctrl, dout[ctrl_width-1:0]);
      exp_ctrl = value[ctrl_width-1:0];
      check_ctrl("ctrl update", exp_ctrl, ctrl_out);
      // Second scan reads the new value back through the loopback
      value = random_bits(ctrl_width);
      // Left differing from the reset value so the TMS reset shows a change
      if (value[ctrl_width-1:0] == ctrl_reset_value)
      begin
         value[ctrl_width-1:0] = ~ctrl_reset_value;
      end
      scan(1'b0, ctrl_width, value, dout);
      check_ctrl("ctrl loopback", exp_ctrl, dout[ctrl_width-1:0]);
      exp_ctrl = value[ctrl_width-1:0];
      check_ctrl("ctrl second update", exp_ctrl, ctrl_out);
   endtask

   task automatic test_status();
      status_t     value;
      logic [15:0] dout;
      load_instr("status ir capture", instr_status);
      value = random_bits(status_width);
      @(posedge atappris_tck);
      #2;
      status_in = value;
      scan(1'b0, status_width, 16'h0000, dout);
      check_status("status capture", value, dout);
      check_ctrl("status ctrl_out", exp_ctrl, ctrl_out);
   endtask

   task automatic test_tms_reset();
      for (int i = 0; i < 5; i++)
      begin
         drive_pins(1'b1, 1'b0);
      end
      drive_pins(1'b0, 1'b0);
      @(negedge atappris_tck);
      #1;
      exp_ctrl = ctrl_reset_value;
      check_ctrl("tms reset ctrl_out", exp_ctrl, ctrl_out);
      test_bypass("bypass after tms reset");
   endtask

   task automatic test_unknown();
      load_instr("unknown ir capture", 4'h6);
      test_bypass("bypass unknown code");
   endtask

   // **********************************************************
   // Sequence and closing report
   // **********************************************************
   initial
   begin
      int waited;
      errors       = 0;
      timeouts     = 0;
      waited       = 0;
      atappris_tms = 1'b1;
      atappris_tdi = 1'b0;
      status_in    = '0;
      lfsr_state   = 32'he799;
      exp_ctrl     = ctrl_reset_value;
      while (!reset_b && waited < wait_limit)
      begin
         @(posedge atappris_tck);
         waited++;
      end
      if (!reset_b)
      begin
         $display("Timeout: reset_b was never released");
         timeouts++;
      end
      test_reset();
      test_ctrl();
      test_status();
      test_tms_reset();
      test_unknown();
      $display("Run finished with %0d check errors, %0d timeouts, %0d assertion failures",
               errors, timeouts, i_tap_top.i_tap_checker.fail_count);
      if (errors == 0 && timeouts == 0 && i_tap_top.i_tap_checker.fail_count == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: list.f
source/tap_pkg.sv
source/tap_fsm.sv
source/tap_instr_reg.sv
source/tap_data_reg.sv
source/tap_top.sv
sim/tap_clock_gen.sv
sim/tap_checker.sv
sim/tap_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tap_tb -f list.f -o tap_sim \
   && ./obj_dir/tap_sim | tee sim.log \
   || echo "Build or simulation returned an error"
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
